//--- common/positPkg.sv
package positPkg;

	// The operation latched at the start of a request.
	typedef enum logic {
		opDiv,
		opSqrt
	} opcode_e;

	// Exception flags reported with every result.
	typedef struct packed {
		logic invalid;
		logic divZero;
		logic inexact;
	} status_t;

	// Width of the signed scale. It covers the difference of two extreme scales, so a
	// quotient scale fits as well, with one bit to spare.
	function automatic int unsigned scaleWidth(
		input int unsigned posWidth,
		input int unsigned expWidth
	);
		int unsigned maxMag;
		maxMag = (2 * (posWidth - 1) + 1) << expWidth;
		return $clog2(maxMag) + 2;
	endfunction

	// Mantissa width including the hidden one.
	function automatic int unsigned mantWidth(
		input int unsigned posWidth,
		input int unsigned expWidth
	);
		return posWidth - expWidth - 1;
	endfunction

endpackage

//--- design/positDecode.sv
module positDecode #(
	parameter int unsigned posWidth = 16,
	parameter int unsigned expWidth = 2,
	localparam int unsigned ScaleW = positPkg::scaleWidth(posWidth, expWidth),
	localparam int unsigned MantW = positPkg::mantWidth(posWidth, expWidth)
) (
	input logic [posWidth-1:0] posit,
	output logic sign,
	output logic signed [ScaleW-1:0] scale,
	output logic [MantW-1:0] mant,
	output logic isNaR,
	output logic isZero
);
	localparam int unsigned RunW = $clog2(posWidth) + 1;

	logic [posWidth-1:0] absPosit;
	logic [posWidth-2:0] body;
	logic [posWidth-2:0] rest;
	logic [RunW-1:0] run;
	logic runDone;
	logic signed [ScaleW-1:0] runExt;
	logic signed [ScaleW-1:0] regime;
	logic [expWidth-1:0] expBits;

	assign sign = posit[posWidth-1];
	assign isZero = (posit == '0);
	assign isNaR = sign && (posit[posWidth-2:0] == '0);

	assign absPosit = sign ? -posit : posit;
	assign body = absPosit[posWidth-2:0];

	// Length of the regime run, counted from the bit below the sign.
	always_comb begin
		run = '0;
		runDone = 1'b0;
		for (int i = posWidth - 2; i >= 0; i--) begin
			if (!runDone && (body[i] == body[posWidth-2])) begin
				run = run + 1'b1;
			end else begin
				runDone = 1'b1;
			end
		end
	end

	// Drop the run and its terminating bit. Bits past the end read as zero.
	assign rest = body << (run + 1'b1);

	assign runExt = ScaleW'(run);
	assign regime = body[posWidth-2] ? runExt - 1'b1 : -runExt;
	assign expBits = rest[posWidth-2 -: expWidth];

	assign scale = (regime <<< expWidth) + $signed({1'b0, expBits});
	assign mant = {1'b1, rest[MantW-1:1]}; // The lowest bit of rest is always zero.

endmodule

//--- divSqrt/mantDivider.sv
module mantDivider #(
	parameter int unsigned posWidth = 16,
	parameter int unsigned expWidth = 2,
	localparam int unsigned ScaleW = positPkg::scaleWidth(posWidth, expWidth),
	localparam int unsigned MantW = positPkg::mantWidth(posWidth, expWidth)
) (
	input logic Clk_CI,
	input logic Rst_RBI,
	input logic Kill,
	input logic Start,
	input logic [MantW-1:0] mantA,
	input logic [MantW-1:0] mantB,
	input logic signed [ScaleW-1:0] scaleA,
	input logic signed [ScaleW-1:0] scaleB,
	output logic Valid,
	output logic [MantW+1:0] quot,
	output logic sticky,
	output logic signed [ScaleW-1:0] scale
);
	localparam int unsigned QuotW = MantW + 2;
	localparam int unsigned CntW = $clog2(QuotW);

	logic busy;
	logic [CntW-1:0] cnt;
	logic [MantW:0] remQ;
	logic [MantW-1:0] divisorQ;
	logic aBelowB;
	logic [MantW:0] remIn;
	logic [MantW-1:0] divisorIn;
	logic [MantW+1:0] diff;
	logic qBit;
	logic [MantW:0] remSel;

	assign aBelowB = (mantA < mantB);

	// The Start cycle already performs the first step on the freshly loaded operands.
	assign remIn = Start ? (aBelowB ? {mantA, 1'b0} : {1'b0, mantA}) : remQ;
	assign divisorIn = Start ? mantB : divisorQ;

	assign diff = {1'b0, remIn} - {2'b00, divisorIn};
	assign qBit = !diff[MantW+1];
	assign remSel = qBit ? diff[MantW:0] : remIn;

	always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
		if (!Rst_RBI) begin
			busy <= 1'b0;
			cnt <= '0;
			Valid <= 1'b0;
		end else begin
			Valid <= 1'b0;
			if (Kill) begin
				busy <= 1'b0;
			end else if (Start) begin
				busy <= 1'b1;
				cnt <= CntW'(QuotW - 1);
			end else if (busy) begin
				cnt <= cnt - 1'b1;
				if (cnt == CntW'(1)) begin
					busy <= 1'b0;
					Valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge Clk_CI) begin
		if (Start || busy) begin
			remQ <= {remSel[MantW-1:0], 1'b0}; // remSel is below the divisor, so no bit is lost.
			divisorQ <= divisorIn;
			quot <= {quot[QuotW-2:0], qBit};
		end
		if (Start) begin
			scale <= scaleA - scaleB - (aBelowB ? ScaleW'(1) : ScaleW'(0));
		end
	end

	assign sticky = |remQ;

	assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) Start |-> !busy)
		else $error("mantDivider started while an operation is running");

endmodule

//--- divSqrt/mantSqrt.sv
module mantSqrt #(
	parameter int unsigned posWidth = 16,
	parameter int unsigned expWidth = 2,
	localparam int unsigned ScaleW = positPkg::scaleWidth(posWidth, expWidth),
	localparam int unsigned MantW = positPkg::mantWidth(posWidth, expWidth)
) (
	input logic Clk_CI,
	input logic Rst_RBI,
	input logic Kill,
	input logic Start,
	input logic [MantW-1:0] mant,
	input logic signed [ScaleW-1:0] scaleIn,
	output logic Valid,
	output logic [MantW+1:0] root,
	output logic sticky,
	output logic signed [ScaleW-1:0] scale
);
	localparam int unsigned RootW = MantW + 2;
	localparam int unsigned RadW = 2 * RootW;
	localparam int unsigned RemW = RootW + 3;
	localparam int unsigned CntW = $clog2(RootW);

	logic busy;
	logic [CntW-1:0] cnt;
	logic [MantW:0] radMant;
	logic [RadW-1:0] radQ;
	logic [RadW-1:0] radIn;
	logic [RemW-1:0] remQ;
	logic [RemW-1:0] remIn;
	logic [RemW-1:0] remSh;
	logic [RootW-1:0] rootIn;
	logic [RemW-1:0] trial;
	logic [RemW:0] diff;
	logic rBit;

	// An odd scale moves one factor of two into the mantissa.
	assign radMant = scaleIn[0] ? {mant, 1'b0} : {1'b0, mant};

	assign radIn = Start ? {radMant, {(MantW + 3){1'b0}}} : radQ;
	assign remIn = Start ? '0 : remQ;
	assign rootIn = Start ? '0 : root;

	// Bring down the next pair of radicand bits and try the digit one.
	assign remSh = {remIn[RemW-3:0], radIn[RadW-1:RadW-2]};
	assign trial = {1'b0, rootIn, 2'b01};
	assign diff = {1'b0, remSh} - {1'b0, trial};
	assign rBit = !diff[RemW];

	always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
		if (!Rst_RBI) begin
			busy <= 1'b0;
			cnt <= '0;
			Valid <= 1'b0;
		end else begin
			Valid <= 1'b0;
			if (Kill) begin
				busy <= 1'b0;
			end else if (Start) begin
				busy <= 1'b1;
				cnt <= CntW'(RootW - 1);
			end else if (busy) begin
				cnt <= cnt - 1'b1;
				if (cnt == CntW'(1)) begin
					busy <= 1'b0;
					Valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge Clk_CI) begin
		if (Start || busy) begin
			radQ <= radIn << 2;
			remQ <= rBit ? diff[RemW-1:0] : remSh;
			root <= {rootIn[RootW-2:0], rBit};
		end
		if (Start) begin
			scale <= scaleIn >>> 1; // Floor halving, exact after the odd correction.
		end
	end

	assign sticky = |remQ;

	assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) Valid |=> !Valid)
		else $error("mantSqrt Valid held for more than one cycle");

endmodule

//--- design/positRound.sv
module positRound #(
	parameter int unsigned posWidth = 16,
	parameter int unsigned expWidth = 2,
	localparam int unsigned ScaleW = positPkg::scaleWidth(posWidth, expWidth),
	localparam int unsigned MantW = positPkg::mantWidth(posWidth, expWidth)
) (
	input logic sign,
	input logic signed [ScaleW-1:0] scale,
	input logic [MantW+1:0] mant,
	input logic sticky,
	input logic forceNaR,
	input logic forceZero,
	output logic [posWidth-1:0] posit,
	output positPkg::status_t flags
);
	localparam int unsigned QuotW = MantW + 2;
	localparam int unsigned VecW = QuotW + expWidth + posWidth - 2;
	localparam int unsigned PadW = posWidth - 3;
	localparam logic signed [ScaleW-1:0] MaxK = ScaleW'(posWidth - 2);
	localparam logic signed [ScaleW-1:0] MinK = -MaxK;

	logic signed [ScaleW-1:0] regime;
	logic [ScaleW-1:0] shamt;
	logic [expWidth-1:0] expBits;
	logic signed [VecW-1:0] base;
	logic signed [VecW-1:0] shifted;
	logic [posWidth-2:0] body;
	logic [posWidth-2:0] bodyRnd;
	logic guard;
	logic rest;
	logic roundUp;
	logic satHi;
	logic satLo;
	logic exactMax;
	logic [posWidth-1:0] magnitude;

	assign regime = scale >>> expWidth;
	assign expBits = scale[expWidth-1:0];

	// The pattern 10 or 01 grows into the regime run by sign filling shifts.
	assign shamt = regime[ScaleW-1] ? ~regime : regime;
	assign base = {~regime[ScaleW-1], regime[ScaleW-1], expBits, mant[QuotW-2:0],
		{PadW{1'b0}}};
	assign shifted = base >>> shamt;

	assign body = shifted[VecW-1 -: posWidth-1];
	assign guard = shifted[VecW-posWidth];
	assign rest = (|shifted[VecW-posWidth-1:0]) || sticky;

	assign roundUp = guard && (body[0] || rest); // Ties go to the even encoding.
	assign bodyRnd = body + roundUp;

	assign satHi = (regime >= MaxK);
	assign satLo = (regime < MinK);
	assign exactMax = (regime == MaxK) && (expBits == '0) && (mant[QuotW-2:0] == '0)
		&& !sticky;

	always_comb begin
		if (satHi) begin
			magnitude = {1'b0, {(posWidth - 1){1'b1}}};
		end else if (satLo) begin
			magnitude = {{(posWidth - 1){1'b0}}, 1'b1};
		end else begin
			magnitude = {1'b0, bodyRnd};
		end
	end

	always_comb begin
		flags = '0;
		if (forceNaR) begin
			posit = {1'b1, {(posWidth - 1){1'b0}}};
			flags.invalid = 1'b1;
		end else if (forceZero) begin
			posit = '0;
		end else begin
			posit = sign ? -magnitude : magnitude;
			flags.inexact = satHi ? !exactMax : (satLo || guard || rest);
		end
	end

endmodule

//--- design/positDivSqrt.sv
module positDivSqrt #(
	parameter int unsigned posWidth = 16,
	parameter int unsigned expWidth = 2,
	localparam int unsigned ScaleW = positPkg::scaleWidth(posWidth, expWidth),
	localparam int unsigned MantW = positPkg::mantWidth(posWidth, expWidth)
) (
	input logic Clk_CI,
	input logic Rst_RBI,
	input logic DivStart,
	input logic SqrtStart,
	input logic Kill,
	input logic [posWidth-1:0] OperandA,
	input logic [posWidth-1:0] OperandB,
	output logic [posWidth-1:0] Result,
	output positPkg::status_t Flags,
	output logic Ready,
	output logic Done
);
	import positPkg::*;

	typedef enum logic [2:0] {
		stIdle,
		stDecode,
		stDiv,
		stSqrt,
		stRound,
		stDone
	} state_e;

	state_e state, stateNext;
	opcode_e opcode;

	logic accept;
	logic inFlight;
	logic [posWidth-1:0] opA, opB;
	logic signA, signB;
	logic signed [ScaleW-1:0] scaleA, scaleB;
	logic [MantW-1:0] mantA, mantB;
	logic narA, narB, zeroA, zeroB;

	logic specNaR, specZero, specDivZero, special;
	logic resSign, forceNaR, forceZero, divZero;

	logic divStartInt, sqrtStartInt;
	logic divValid, sqrtValid;
	logic [MantW+1:0] divQuot, sqrtRoot, rndMant;
	logic divSticky, sqrtSticky, rndSticky;
	logic signed [ScaleW-1:0] divScale, sqrtScale, rndScale;
	logic [posWidth-1:0] rndPosit;
	status_t rndFlags;

	assign accept = Ready && (DivStart || SqrtStart);
	assign inFlight = (state inside {stDecode, stDiv, stSqrt, stRound});

	positDecode #(.posWidth(posWidth), .expWidth(expWidth)) decodeA_i (
		.posit(opA), .sign(signA), .scale(scaleA), .mant(mantA),
		.isNaR(narA), .isZero(zeroA)
	);

	positDecode #(.posWidth(posWidth), .expWidth(expWidth)) decodeB_i (
		.posit(opB), .sign(signB), .scale(scaleB), .mant(mantB),
		.isNaR(narB), .isZero(zeroB)
	);

	// Special operands are settled here and bypass the iterative units.
	always_comb begin
		if (opcode == opDiv) begin
			specDivZero = zeroB;
			specNaR = narA || narB || zeroB;
		end else begin
			specDivZero = 1'b0;
			specNaR = narA || (signA && !zeroA);
		end
	end
	assign specZero = zeroA;
	assign special = specNaR || specZero;

	assign divStartInt = (state == stDecode) && !Kill && !special && (opcode == opDiv);
	assign sqrtStartInt = (state == stDecode) && !Kill && !special && (opcode == opSqrt);

	mantDivider #(.posWidth(posWidth), .expWidth(expWidth)) mantDivider_i (
		.Clk_CI, .Rst_RBI, .Kill, .Start(divStartInt),
		.mantA(mantA), .mantB(mantB), .scaleA(scaleA), .scaleB(scaleB),
		.Valid(divValid), .quot(divQuot), .sticky(divSticky), .scale(divScale)
	);

	mantSqrt #(.posWidth(posWidth), .expWidth(expWidth)) mantSqrt_i (
		.Clk_CI, .Rst_RBI, .Kill, .Start(sqrtStartInt),
		.mant(mantA), .scaleIn(scaleA),
		.Valid(sqrtValid), .root(sqrtRoot), .sticky(sqrtSticky), .scale(sqrtScale)
	);

	assign rndMant = (opcode == opDiv) ? divQuot : sqrtRoot;
	assign rndSticky = (opcode == opDiv) ? divSticky : sqrtSticky;
	assign rndScale = (opcode == opDiv) ? divScale : sqrtScale;

	positRound #(.posWidth(posWidth), .expWidth(expWidth)) positRound_i (
		.sign(resSign), .scale(rndScale), .mant(rndMant), .sticky(rndSticky),
		.forceNaR(forceNaR), .forceZero(forceZero), .posit(rndPosit), .flags(rndFlags)
	);

	always_comb begin
		stateNext = state;
		unique case (state)
			stIdle, stDone: stateNext = accept ? stDecode : stIdle;
			stDecode: stateNext = special ? stRound : ((opcode == opDiv) ? stDiv : stSqrt);
			stDiv: if (divValid) stateNext = stRound;
			stSqrt: if (sqrtValid) stateNext = stRound;
			stRound: stateNext = stDone;
			default: stateNext = stIdle;
		endcase
		if (Kill && inFlight) begin
			stateNext = stIdle; // Abort drops the operation without a Done.
		end
	end

	always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
		if (!Rst_RBI) begin
			state <= stIdle;
			opcode <= opDiv;
			Ready <= 1'b1;
			Done <= 1'b0;
			Result <= '0;
			Flags <= '0;
		end else begin
			state <= stateNext;
			Done <= (state == stRound) && !Kill;
			if (accept) begin
				opcode <= DivStart ? opDiv : opSqrt; // Division wins a tie.
				Ready <= 1'b0;
			end else if ((state == stRound) || (Kill && inFlight)) begin
				Ready <= 1'b1;
			end
			if ((state == stRound) && !Kill) begin
				Result <= rndPosit;
				Flags <= '{invalid: rndFlags.invalid, divZero: divZero,
					inexact: rndFlags.inexact};
			end
		end
	end

	always_ff @(posedge Clk_CI) begin
		if (accept) begin
			opA <= OperandA;
			opB <= OperandB;
		end
		if (state == stDecode) begin
			resSign <= (opcode == opDiv) && (signA ^ signB);
			forceNaR <= specNaR;
			forceZero <= specZero;
			divZero <= specDivZero;
		end
	end

	assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) Done |-> $past(state) == stRound)
		else $error("Done raised without a preceding rounding cycle");

	assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) (state == stIdle) |-> (Ready || Done))
		else $error("Idle while neither ready nor done");

endmodule

//--- dv/positRefModel.svh
`ifndef POSIT_REF_MODEL_SVH
`define POSIT_REF_MODEL_SVH

// Magnitude is mant * 2^(scale - (MantW - 1)), with the hidden one at bit MantW - 1.
function automatic void decodePosit(
	input logic [PosW-1:0] p,
	output logic sign,
	output int scale,
	output longint unsigned mant
);
	logic [PosW-1:0] mag;
	logic lead;
	int pos;
	int run;
	int expVal;
	sign = p[PosW-1];
	mag = sign ? -p : p;
	lead = mag[PosW-2];
	pos = PosW - 2;
	run = 0;
	while (pos >= 0 && mag[pos] == lead) begin
		run++;
		pos--;
	end
	pos--; // Skip the bit that ends the regime.
	expVal = 0;
	for (int i = 0; i < ExpW; i++) begin
		expVal = 2 * expVal + ((pos >= 0) ? int'(mag[pos]) : 0);
		pos--;
	end
	mant = 1;
	for (int i = 0; i < MantW - 1; i++) begin
		mant = 2 * mant + ((pos >= 0) ? longint'(mag[pos]) : 0);
		pos--;
	end
	scale = (lead ? run - 1 : -run) * (1 << ExpW) + expVal;
endfunction

// Value is (1 + frac / 2^fracBits) * 2^scale, and sticky marks a nonzero tail.
function automatic void encodePosit(
	input logic sign,
	input int scale,
	input longint unsigned frac,
	input int fracBits,
	input logic sticky,
	output logic [PosW-1:0] res,
	output logic inexact
);
	logic str [0:127];
	int n;
	int k;
	int expVal;
	logic [PosW-2:0] body;
	logic guard;
	logic rest;
	logic [PosW-1:0] mag;
	k = scale >>> ExpW;
	expVal = scale - k * (1 << ExpW);
	if (k >= PosW - 2) begin
		mag = MaxPos;
		inexact = !(k == PosW - 2 && expVal == 0 && frac == 0 && !sticky);
	end else if (k < -(PosW - 2)) begin
		mag = MinPos; // Nonzero values never round to zero.
		inexact = 1'b1;
	end else begin
		n = 0;
		for (int i = 0; i < ((k >= 0) ? k + 1 : -k); i++) begin
			str[n] = (k >= 0);
			n++;
		end
		str[n] = (k < 0);
		n++;
		for (int i = ExpW - 1; i >= 0; i--) begin
			str[n] = expVal[i];
			n++;
		end
		for (int i = fracBits - 1; i >= 0; i--) begin
			str[n] = frac[i];
			n++;
		end
		body = '0;
		for (int i = 0; i < PosW - 1; i++) begin
			body = {body[PosW-3:0], (i < n) ? str[i] : 1'b0};
		end
		guard = (PosW - 1 < n) ? str[PosW-1] : 1'b0;
		rest = sticky;
		for (int i = PosW; i < n; i++) begin
			rest = rest | str[i];
		end
		if (guard && (body[0] || rest)) begin
			body = body + 1'b1; // Round to nearest, ties to the even bit string.
		end
		mag = {1'b0, body};
		inexact = guard | rest;
	end
	res = sign ? -mag : mag;
endfunction

function automatic void divideExact(
	input logic [PosW-1:0] a,
	input logic [PosW-1:0] b,
	output logic [PosW-1:0] res,
	output status_t flg
);
	logic signA;
	logic signB;
	logic inexact;
	int scaleA;
	int scaleB;
	int lead;
	longint unsigned mA;
	longint unsigned mB;
	longint unsigned q;
	longint unsigned r;
	flg = '0;
	res = '0;
	if (a == NaR || b == NaR || b == '0) begin
		res = NaR;
		flg.invalid = 1'b1;
		flg.divZero = (b == '0);
	end else if (a != '0) begin
		decodePosit(a, signA, scaleA, mA);
		decodePosit(b, signB, scaleB, mB);
		q = (mA << 40) / mB;
		r = (mA << 40) % mB;
		lead = 63;
		while (lead > 0 && !q[lead]) begin
			lead--;
		end
		encodePosit(signA ^ signB, scaleA - scaleB + lead - 40, q - (64'd1 << lead), lead,
			r != 0, res, inexact);
		flg.inexact = inexact;
	end
endfunction

function automatic void sqrtExact(
	input logic [PosW-1:0] a,
	output logic [PosW-1:0] res,
	output status_t flg
);
	logic sign;
	logic inexact;
	int scale;
	int t;
	int lead;
	longint unsigned m;
	logic [63:0] rad;
	logic [63:0] root;
	logic [63:0] cand;
	flg = '0;
	res = '0;
	if (a[PosW-1]) begin
		res = NaR; // Covers NaR and every negative operand.
		flg.invalid = 1'b1;
	end else if (a != '0) begin
		decodePosit(a, sign, scale, m);
		t = scale - (MantW - 1);
		if (t % 2 != 0) begin
			m = m * 2;
			t = t - 1;
		end
		rad = m << 40;
		root = '0;
		for (int i = 31; i >= 0; i--) begin
			cand = root | (64'd1 << i);
			if (cand * cand <= rad) begin
				root = cand;
			end
		end
		lead = 63;
		while (lead > 0 && !root[lead]) begin
			lead--;
		end
		encodePosit(1'b0, t / 2 - 20 + lead, root - (64'd1 << lead), lead,
			(rad - root * root) != 0, res, inexact);
		flg.inexact = inexact;
	end
endfunction

`endif

//--- dv/tbPositDivSqrt.sv
module tbPositDivSqrt;
	timeunit 1ns;
	timeprecision 100ps;

	import positPkg::*;

	localparam int PosW = 16;
	localparam int ExpW = 2;
	localparam int MantW = int'(mantWidth(PosW, ExpW));
	localparam int NumDiv = 300;
	localparam int NumSqrt = 300;
	localparam int NumDirected = 13;
	localparam int NumKill = 20;
	localparam int NumOps = NumDiv + NumSqrt + NumDirected + 2 * NumKill;
	localparam int OpLimit = MantW + 10;
	localparam int CycleLimit = NumOps * OpLimit + 4;
	localparam logic [PosW-1:0] NaR = {1'b1, {(PosW - 1){1'b0}}};
	localparam logic [PosW-1:0] MaxPos = {1'b0, {(PosW - 1){1'b1}}};
	localparam logic [PosW-1:0] MinPos = {{(PosW - 1){1'b0}}, 1'b1};
	localparam logic [PosW-1:0] One = {2'b01, {(PosW - 2){1'b0}}};
	localparam status_t NoFlags = '0;
	localparam status_t InvFlags = '{invalid: 1'b1, divZero: 1'b0, inexact: 1'b0};
	localparam status_t DivZFlags = '{invalid: 1'b1, divZero: 1'b1, inexact: 1'b0};
	localparam status_t InexFlags = '{invalid: 1'b0, divZero: 1'b0, inexact: 1'b1};

	logic Clk_CI;
	logic Rst_RBI;
	logic DivStart;
	logic SqrtStart;
	logic Kill;
	logic [PosW-1:0] OperandA;
	logic [PosW-1:0] OperandB;
	logic [PosW-1:0] Result;
	status_t Flags;
	logic Ready;
	logic Done;

	logic [15:0] lfsr;
	logic [PosW-1:0] lastResult;
	status_t lastFlags;
	int cycleCount = 0;
	int resultErrors = 0;
	int flagErrors = 0;
	int protoErrors = 0;

	positDivSqrt #(.posWidth(PosW), .expWidth(ExpW)) positDivSqrt_i (
		.Clk_CI, .Rst_RBI, .DivStart, .SqrtStart, .Kill, .OperandA, .OperandB,
		.Result, .Flags, .Ready, .Done
	);

	always #2 Clk_CI = ~Clk_CI;

	always @(posedge Clk_CI) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
			$display("** FAIL **");
			$finish;
		end
	end

	`include "positRefModel.svh"

	// Taps at bits 16, 14, 13 and 11.
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [PosW-1:0] randOperand(input logic positive);
		logic [2:0] sel;
		logic [PosW-1:0] val;
		sel = 3'(randBits(3));
		val = PosW'(randBits(PosW));
		if (sel == 3'd0) begin
			val = '0;
		end else if (sel == 3'd1) begin
			val = NaR;
		end else if (positive && sel != 3'd2) begin
			val[PosW-1] = 1'b0;
		end
		return val;
	endfunction

	function automatic logic bypassesIteration(input opcode_e op, input logic [PosW-1:0] a,
		input logic [PosW-1:0] b);
		if (op == opDiv) begin
			return a == NaR || b == NaR || a == '0 || b == '0;
		end
		return a == '0 || a[PosW-1];
	endfunction

	task automatic checkResult(input string name, input logic [PosW-1:0] expected,
		input logic [PosW-1:0] actual);
		if (actual !== expected) begin
			resultErrors++;
			$display("** Error %s: result expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkFlags(input string name, input status_t expected, input status_t actual);
		if (actual !== expected) begin
			flagErrors++;
			$display("** Error %s: flags expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic protocolError(input string msg);
		protoErrors++;
		$display("%s", msg);
	endtask

	// Called at a falling edge, so Ready is stable here.
	task automatic startOp(input opcode_e op, input logic [PosW-1:0] a,
		input logic [PosW-1:0] b, input string name);
		if (!Ready) begin
			protocolError($sformatf("%s: DUT was not ready for a new request", name));
		end
		@(posedge Clk_CI);
		DivStart <= (op == opDiv);
		SqrtStart <= (op == opSqrt) || (randBits(1) == 32'd1); // A tie must pick division.
		OperandA <= a;
		OperandB <= b;
		@(posedge Clk_CI);
		DivStart <= 1'b0;
		SqrtStart <= 1'b0;
		OperandA <= PosW'(randBits(PosW));
		OperandB <= PosW'(randBits(PosW));
	endtask

	task automatic runOp(input opcode_e op, input logic [PosW-1:0] a, input logic [PosW-1:0] b,
		input logic [PosW-1:0] expRes, input status_t expFlags, input string name);
		int waited;
		bit gotDone;
		startOp(op, a, b, name);
		waited = 0;
		gotDone = 1'b0;
		while (!gotDone && waited < OpLimit) begin
			@(negedge Clk_CI);
			waited++;
			gotDone = Done;
			if (!Done && Ready) begin
				protocolError($sformatf("%s: Ready rose before Done", name));
			end
		end
		if (!gotDone) begin
			protocolError($sformatf("%s: no Done within %0d cycles", name, OpLimit));
		end else begin
			if (!Ready) begin
				protocolError($sformatf("%s: Ready was low on the Done cycle", name));
			end
			checkResult(name, expRes, Result);
			checkFlags(name, expFlags, Flags);
			lastResult = expRes;
			lastFlags = expFlags;
			@(negedge Clk_CI);
			if (Done) begin
				protocolError($sformatf("%s: Done stayed high for more than one cycle", name));
			end
		end
	endtask

	task automatic runModelOp(input opcode_e op, input logic [PosW-1:0] a,
		input logic [PosW-1:0] b, input string name);
		logic [PosW-1:0] expRes;
		status_t expFlags;
		if (op == opDiv) begin
			divideExact(a, b, expRes, expFlags);
		end else begin
			sqrtExact(a, expRes, expFlags);
		end
		runOp(op, a, b, expRes, expFlags, name);
	endtask

	task automatic killOp(input string name);
		opcode_e op;
		logic [PosW-1:0] a;
		logic [PosW-1:0] b;
		int delay;
		bit sawDone;
		op = (randBits(1) == 32'd1) ? opSqrt : opDiv;
		a = randOperand(op == opSqrt);
		b = randOperand(1'b0);
		// The kill must land while the operation is still in flight.
		delay = bypassesIteration(op, a, b) ? int'(randBits(1)) : int'(randBits(4)) % (MantW + 3);
		startOp(op, a, b, name);
		sawDone = 1'b0;
		for (int i = 0; i < delay; i++) begin
			@(negedge Clk_CI);
			sawDone |= Done;
			@(posedge Clk_CI);
		end
		Kill <= 1'b1;
		@(negedge Clk_CI);
		sawDone |= Done;
		@(posedge Clk_CI);
		Kill <= 1'b0;
		@(negedge Clk_CI);
		sawDone |= Done;
		if (sawDone) begin
			protocolError($sformatf("%s: Done was pulsed for a killed operation", name));
		end
		if (!Ready) begin
			protocolError($sformatf("%s: Ready did not return after the kill", name));
		end
		checkResult(name, lastResult, Result);
		checkFlags(name, lastFlags, Flags);
	endtask

	initial begin
		Clk_CI = 1'b0;
		Rst_RBI = 1'b0;
		DivStart = 1'b0;
		SqrtStart = 1'b0;
		Kill = 1'b0;
		OperandA = '0;
		OperandB = '0;
		lfsr = 16'd13;
		lastResult = '0;
		lastFlags = '0;
		repeat (2) @(posedge Clk_CI);
		Rst_RBI <= 1'b1;
		@(negedge Clk_CI);
		if (!Ready || Done) begin
			protocolError("reset: Ready should be high and Done low after reset");
		end
		checkResult("reset", '0, Result);
		checkFlags("reset", NoFlags, Flags);

		runOp(opDiv, NaR, One, NaR, InvFlags, "NaR/1");
		runOp(opDiv, One, NaR, NaR, InvFlags, "1/NaR");
		runOp(opDiv, One, '0, NaR, DivZFlags, "1/0");
		runOp(opDiv, '0, '0, NaR, DivZFlags, "0/0");
		runOp(opDiv, '0, One, '0, NoFlags, "0/1");
		runOp(opSqrt, NaR, '0, NaR, InvFlags, "sqrt NaR");
		runOp(opSqrt, 16'hC000, '0, NaR, InvFlags, "sqrt -1");
		runOp(opSqrt, '0, One, '0, NoFlags, "sqrt 0");
		runOp(opDiv, MaxPos, MinPos, MaxPos, InexFlags, "maxpos/minpos");
		runOp(opDiv, MinPos, MaxPos, MinPos, InexFlags, "minpos/maxpos");
		runOp(opDiv, -MaxPos, MinPos, -MaxPos, InexFlags, "-maxpos/minpos");
		runOp(opSqrt, 16'h5000, '0, 16'h4800, NoFlags, "sqrt 4");
		runOp(opDiv, One, One, One, NoFlags, "1/1");

		for (int i = 0; i < NumDiv; i++) begin
			runModelOp(opDiv, randOperand(1'b0), randOperand(1'b0), $sformatf("div %0d", i));
		end
		for (int i = 0; i < NumSqrt; i++) begin
			runModelOp(opSqrt, randOperand(1'b1), '0, $sformatf("sqrt %0d", i));
		end
		for (int i = 0; i < NumKill; i++) begin
			killOp($sformatf("kill %0d", i));
			runModelOp(opDiv, randOperand(1'b0), randOperand(1'b0),
				$sformatf("after kill %0d", i));
		end

		$display("Errors: result %0d, flags %0d, protocol %0d", resultErrors, flagErrors,
			protoErrors);
		if (resultErrors + flagErrors + protoErrors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+dv
common/positPkg.sv
design/positDecode.sv
divSqrt/mantDivider.sv
divSqrt/mantSqrt.sv
design/positRound.sv
design/positDivSqrt.sv
dv/tbPositDivSqrt.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tbPositDivSqrt -f files.f

simOut="$(./obj_dir/VtbPositDivSqrt 2>&1 || true)"
echo "$simOut"

if grep -qxF '** PASS **' <<< "$simOut"; then
	exit 0
fi
exit 1
